//--- Makefile
VERILATOR ?= verilator
TOP       ?= clint_tb
FILELIST  ?= clint.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build clint_tb with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation PASS"; \
	else \
	  echo "Simulation FAIL"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- clint.f
clintPkg.sv
clintBusSlave.sv
mtimeCounter.sv
clintRegs.sv
clint.sv
clint_checker.sv
clint_tb.sv

//--- clint.sv
`default_nettype none

module clint (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  // Wishbone classic slave port
  input  logic                           wbCyc,
  input  logic                           wbStb,
  input  logic                           wbWe,
  input  logic [clintPkg::addrWidth-1:0] wbAdr,
  input  logic [clintPkg::byteLanes-1:0] wbSel,
  input  logic [clintPkg::dataWidth-1:0] wbDatW,
  output logic [clintPkg::dataWidth-1:0] wbDatR,
  output logic                           wbAck,
  // Machine time for the hart time CSR
  output logic [clintPkg::timeWidth-1:0] mtime,
  // Interrupt lines to the hart
  output logic                           mTimerInt,
  output logic                           mSwInt
);

  import clintPkg::*;

  // Write port shared by the counter and the register block
  clintReg_e            regSel;
  logic                 writeEn;
  logic [byteLanes-1:0] byteEn;
  logic [dataWidth-1:0] writeData;

  // Register state fed back to the read multiplexer
  logic [timeWidth-1:0] mtimeCmp;
  logic                 msip;

  //////////////////////////////////////////////////////////////////////
  // Bus interface
  //////////////////////////////////////////////////////////////////////

  clintBusSlave busSlave (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbWe      (wbWe),
    .wbAdr     (wbAdr),
    .wbSel     (wbSel),
    .wbDatW    (wbDatW),
    .wbDatR    (wbDatR),
    .wbAck     (wbAck),
    .mtime     (mtime),
    .mtimeCmp  (mtimeCmp),
    .msip      (msip),
    .regSel    (regSel),
    .writeEn   (writeEn),
    .byteEn    (byteEn),
    .writeData (writeData)
  );

  //////////////////////////////////////////////////////////////////////
  // Timebase and interrupt registers
  //////////////////////////////////////////////////////////////////////

  // Counter runs on HCLK, the only timebase this design supports
  mtimeCounter timeCounter (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .regSel    (regSel),
    .writeEn   (writeEn),
    .byteEn    (byteEn),
    .writeData (writeData),
    .mtime     (mtime)
  );

  clintRegs regs (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .regSel    (regSel),
    .writeEn   (writeEn),
    .byteEn    (byteEn),
    .writeData (writeData),
    .mtime     (mtime),
    .mtimeCmp  (mtimeCmp),
    .msip      (msip),
    .mTimerInt (mTimerInt),
    .mSwInt    (mSwInt)
  );

endmodule

`default_nettype wire

//--- clintBusSlave.sv
`default_nettype none

module clintBusSlave (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  // Wishbone classic slave side
  input  logic                             wbCyc,
  input  logic                             wbStb,
  input  logic                             wbWe,
  input  logic [clintPkg::addrWidth-1:0]   wbAdr,
  input  logic [clintPkg::byteLanes-1:0]   wbSel,
  input  logic [clintPkg::dataWidth-1:0]   wbDatW,
  output logic [clintPkg::dataWidth-1:0]   wbDatR,
  output logic                             wbAck,
  // Register values returned for reads
  input  logic [clintPkg::timeWidth-1:0]   mtime,
  input  logic [clintPkg::timeWidth-1:0]   mtimeCmp,
  input  logic                             msip,
  // Write port toward the counter and the register block
  output clintPkg::clintReg_e              regSel,
  output logic                             writeEn,
  output logic [clintPkg::byteLanes-1:0]   byteEn,
  output logic [clintPkg::dataWidth-1:0]   writeData
);

  import clintPkg::*;

  logic                 request;
  logic [addrWidth-1:0] wordAdr;
  clintReg_e            decodedSel;
  logic [dataWidth-1:0] readMux;

  //////////////////////////////////////////////////////////////////////
  // Request and address decode
  //////////////////////////////////////////////////////////////////////

  // A new access is taken only while no acknowledge is pending
  // This gives every access a fixed two-cycle cost
  assign request = wbCyc & wbStb & ~wbAck;

  // Accesses are word aligned
  // Byte positions inside the word come from the select lines
  assign wordAdr = {wbAdr[addrWidth-1:2], 2'b00};

  always_comb begin
    case (wordAdr)
      msipAddr:       decodedSel = regMsip;
      mtimeCmpLoAddr: decodedSel = regCmpLo;
      mtimeCmpHiAddr: decodedSel = regCmpHi;
      mtimeLoAddr:    decodedSel = regTimeLo;
      mtimeHiAddr:    decodedSel = regTimeHi;
      // Anything outside the map reads zero and drops writes
      default:        decodedSel = regNone;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Read multiplexer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (decodedSel)
      // Only bit 0 of the msip word is implemented
      regMsip:   readMux = {{(dataWidth-1){1'b0}}, msip};
      regCmpLo:  readMux = mtimeCmp[dataWidth-1:0];
      regCmpHi:  readMux = mtimeCmp[timeWidth-1:dataWidth];
      regTimeLo: readMux = mtime[dataWidth-1:0];
      regTimeHi: readMux = mtime[timeWidth-1:dataWidth];
      default:   readMux = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake and write strobe
  //////////////////////////////////////////////////////////////////////

  // The acknowledge is high for the cycle after the request was sampled
  // The write strobe rides in the same cycle so targets update one edge later
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wbAck   <= 1'b0;
      writeEn <= 1'b0;
      regSel  <= regNone;
    end else begin
      wbAck   <= request;
      writeEn <= request & wbWe;
      // Target is held after the access so it stays stable around the strobe
      if (request) begin
        regSel <= decodedSel;
      end
    end
  end

  // Payload captured with the request
  // Read data is valid while wbAck is high
  always_ff @(posedge HCLK) begin
    if (request) begin
      wbDatR    <= readMux;
      byteEn    <= wbSel;
      writeData <= wbDatW;
    end
  end

endmodule

`default_nettype wire

//--- clintPkg.sv
`default_nettype none

package clintPkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and counter widths
  //////////////////////////////////////////////////////////////////////

  // Wishbone data width for the 32-bit hart
  localparam int dataWidth = 32;
  // One select line per byte of the data bus
  localparam int byteLanes = dataWidth / 8;
  // Word address space of the CLINT window
  localparam int addrWidth = 16;
  // Machine time and compare registers are always 64 bits
  localparam int timeWidth = 64;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  localparam logic [addrWidth-1:0] msipAddr       = 16'h0000;
  localparam logic [addrWidth-1:0] mtimeCmpLoAddr = 16'h4000;
  localparam logic [addrWidth-1:0] mtimeCmpHiAddr = 16'h4004;
  localparam logic [addrWidth-1:0] mtimeLoAddr    = 16'hBFF8;
  localparam logic [addrWidth-1:0] mtimeHiAddr    = 16'hBFFC;

  // Compare value out of reset sits at the top of the range
  // No timer interrupt can fire before software programs it
  localparam logic [timeWidth-1:0] mtimeCmpReset = {timeWidth{1'b1}};

  // Register targeted by one bus access
  typedef enum logic [2:0] {
    regNone,
    regMsip,
    regCmpLo,
    regCmpHi,
    regTimeLo,
    regTimeHi
  } clintReg_e;

  // Replace the bytes of oldWord whose select bit is set
  function automatic logic [dataWidth-1:0] byteMerge(
    input logic [dataWidth-1:0] oldWord,
    input logic [dataWidth-1:0] newWord,
    input logic [byteLanes-1:0] laneSel
  );
    logic [dataWidth-1:0] merged;
    merged = oldWord;
    for (int i = 0; i < byteLanes; i++) begin
      if (laneSel[i]) begin
        merged[8*i +: 8] = newWord[8*i +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

//--- clintRegs.sv
`default_nettype none

module clintRegs (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  // Registered write port from the bus slave
  input  clintPkg::clintReg_e            regSel,
  input  logic                           writeEn,
  input  logic [clintPkg::byteLanes-1:0] byteEn,
  input  logic [clintPkg::dataWidth-1:0] writeData,
  // Current machine time for the comparator
  input  logic [clintPkg::timeWidth-1:0] mtime,
  // Register state returned to the read multiplexer
  output logic [clintPkg::timeWidth-1:0] mtimeCmp,
  output logic                           msip,
  // Interrupt lines to the hart
  output logic                           mTimerInt,
  output logic                           mSwInt
);

  import clintPkg::*;

  logic writeCmpLo;
  logic writeCmpHi;
  logic writeMsip;

  // Decode the strobe into one enable per register
  assign writeCmpLo = writeEn & (regSel == regCmpLo);
  assign writeCmpHi = writeEn & (regSel == regCmpHi);
  // msip lives in byte 0, so lane 0 must be selected for it to change
  assign writeMsip  = writeEn & (regSel == regMsip) & byteEn[0];

  //////////////////////////////////////////////////////////////////////
  // Compare register
  //////////////////////////////////////////////////////////////////////

  // Each half is written independently with byte-lane merging
  // A 64-bit compare value therefore takes two bus writes
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      mtimeCmp <= mtimeCmpReset;
    end else if (writeCmpLo) begin
      mtimeCmp[dataWidth-1:0] <= byteMerge(mtimeCmp[dataWidth-1:0], writeData, byteEn);
    end else if (writeCmpHi) begin
      mtimeCmp[timeWidth-1:dataWidth] <=
        byteMerge(mtimeCmp[timeWidth-1:dataWidth], writeData, byteEn);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Software interrupt pending bit
  //////////////////////////////////////////////////////////////////////

  // Software sets and clears this bit directly
  // Upper bits of the written word are ignored
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      msip <= 1'b0;
    end else if (writeMsip) begin
      msip <= writeData[0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Interrupt outputs
  //////////////////////////////////////////////////////////////////////

  // Timer interrupt stays asserted while time has reached the compare value
  // Both operands are unsigned 64-bit vectors
  // Software clears it by moving mtimeCmp past the current time
  assign mTimerInt = (mtime >= mtimeCmp);

  // Software interrupt mirrors the pending bit
  assign mSwInt = msip;

endmodule

`default_nettype wire

//--- clint_checker.sv
`default_nettype none

module clint_checker (
  input logic                           HCLK,
  input logic                           HRESETn,
  input logic                           wbCyc,
  input logic                           wbStb,
  input logic                           wbAck,
  input logic [clintPkg::timeWidth-1:0] mtime,
  input logic [clintPkg::timeWidth-1:0] mtimeCmp,
  input logic                           msip,
  input logic                           mTimerInt,
  input logic                           mSwInt
);

  //////////////////////////////////////////////////////////////////////
  // Wishbone handshake
  //////////////////////////////////////////////////////////////////////

  // The acknowledge is a single-cycle pulse
  ackPulse: assert property (@(posedge HCLK) disable iff (!HRESETn) wbAck |=> !wbAck)
    else $error("wbAck stayed high for two cycles");

  // An acknowledge answers a request seen on the cycle before
  ackAfterRequest: assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(wbAck) |-> $past(wbCyc && wbStb))
    else $error("wbAck rose without a request on the previous cycle");

  // The bus comes out of reset idle
  ackIdleAfterReset: assert property (@(posedge HCLK) $rose(HRESETn) |-> !wbAck)
    else $error("wbAck high in the first cycle after reset");

  //////////////////////////////////////////////////////////////////////
  // Interrupt outputs
  //////////////////////////////////////////////////////////////////////

  timerCompare: assert property (@(posedge HCLK) disable iff (!HRESETn)
    mTimerInt == (mtime >= mtimeCmp))
    else $error("mTimerInt does not match the unsigned mtime compare");

  swFollowsMsip: assert property (@(posedge HCLK) disable iff (!HRESETn) mSwInt == msip)
    else $error("mSwInt does not follow msip");

endmodule

// Internal registers of the top level are reached through the bind scope
bind clint clint_checker ruleCheck (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .wbCyc     (wbCyc),
  .wbStb     (wbStb),
  .wbAck     (wbAck),
  .mtime     (mtime),
  .mtimeCmp  (mtimeCmp),
  .msip      (msip),
  .mTimerInt (mTimerInt),
  .mSwInt    (mSwInt)
);

`default_nettype wire

//--- clint_tb.sv
`default_nettype none

module clint_tb;

  import clintPkg::*;

  // The six tests need under 1000 cycles so 20000 leaves a wide margin
  localparam int watchdogCycles = 20000;
  localparam int ackLimit = 16;
  // Timer is armed 200 ticks ahead plus slack for the bus accesses
  localparam int timerLimit = 260;
  localparam logic [31:0] timeLoStart = 32'h1000_0000;
  localparam logic [31:0] timeHiStart = 32'h0000_1234;
  // Word addresses that fall between the mapped registers
  localparam logic [15:0] unmappedAddrs [5] = '{16'h0004, 16'h2000, 16'h4008, 16'hBFF4,
                                                16'hFFFC};

  logic                 HCLK = 1'b0;
  logic                 HRESETn;
  logic                 wbCyc;
  logic                 wbStb;
  logic                 wbWe;
  logic [addrWidth-1:0] wbAdr;
  logic [byteLanes-1:0] wbSel;
  logic [dataWidth-1:0] wbDatW;
  logic [dataWidth-1:0] wbDatR;
  logic                 wbAck;
  logic [timeWidth-1:0] mtime;
  logic                 mTimerInt;
  logic                 mSwInt;

  // Reference model of the software-visible registers
  logic [63:0] expCmp;
  logic        expMsip;
  logic [31:0] rngState;

  // Checks waiting for the compare process
  string       chkName[$];
  logic [63:0] chkExp[$];
  logic [63:0] chkAct[$];

  string curTest;
  int    testErrors;
  int    testsPassed;
  int    testsFailed;

  clint dut (.*);

  always #50 HCLK = ~HCLK;

  //////////////////////////////////////////////////////////////////////
  // Reference functions
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // Expected register word after a write under a byte select mask
  function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                             input logic [31:0] newWord,
                                             input logic [3:0]  sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (oldWord & ~mask) | (newWord & mask);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checking and reporting
  //////////////////////////////////////////////////////////////////////

  task automatic compareValues(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: %s expected %h actual %h", curTest, name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic expectValue(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    chkName.push_back(name);
    chkExp.push_back(expected);
    chkAct.push_back(actual);
  endtask

  // Compare process drains the pending checks on every falling edge
  always @(negedge HCLK) begin
    while (chkName.size() > 0) begin
      compareValues(chkName.pop_front(), chkExp.pop_front(), chkAct.pop_front());
    end
  end

  task automatic beginTest(input string name);
    curTest = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    while (chkName.size() > 0) begin
      @(negedge HCLK);
    end
    @(negedge HCLK);
    if (testErrors == 0) begin
      testsPassed++;
      $display("PASS %s", curTest);
    end else begin
      testsFailed++;
      $display("FAIL %s with %0d errors", curTest, testErrors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Wishbone master
  //////////////////////////////////////////////////////////////////////

  // wbAck is looked at on falling edges where it is stable
  task automatic waitAck(input logic [15:0] adr);
    int cycles;
    cycles = 0;
    do begin
      @(negedge HCLK);
      cycles++;
    end while (!wbAck && cycles < ackLimit);
    if (!wbAck) begin
      $display("No acknowledge from the DUT for address %h within %0d cycles", adr, ackLimit);
      testErrors++;
    end
  endtask

  task automatic wbAccess(input logic we, input logic [15:0] adr, input logic [31:0] data,
                          input logic [3:0] sel, output logic [31:0] rdata);
    @(negedge HCLK);
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = we;
    wbAdr = adr;
    wbSel = sel;
    wbDatW = data;
    waitAck(adr);
    rdata = wbDatR;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
  endtask

  task automatic wbWrite(input logic [15:0] adr, input logic [31:0] data,
                         input logic [3:0] sel);
    logic [31:0] unused;
    wbAccess(1'b1, adr, data, sel, unused);
  endtask

  task automatic wbRead(input logic [15:0] adr, output logic [31:0] data);
    wbAccess(1'b0, adr, 32'd0, 4'hF, data);
  endtask

  task automatic readCheck(input string name, input logic [15:0] adr, input logic [31:0] exp);
    logic [31:0] got;
    wbRead(adr, got);
    expectValue(name, 64'(exp), 64'(got));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    repeat (watchdogCycles) @(posedge HCLK);
    $display("Watchdog expired after %0d cycles, the run is stuck", watchdogCycles);
    $display("tests failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] lo1;
    logic [31:0] lo2;
    logic [31:0] hi;
    logic [31:0] data;
    logic [31:0] rnd;
    logic [63:0] target;
    int          waited;
    rngState = 32'ha00a;
    HRESETn = 1'b0;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbSel = '0;
    wbDatW = '0;
    // Compare register resets to all ones, msip to zero
    expCmp = 64'hFFFF_FFFF_FFFF_FFFF;
    expMsip = 1'b0;
    testsPassed = 0;
    testsFailed = 0;
    repeat (16) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;

    beginTest("reset state");
    readCheck("msip", msipAddr, {31'd0, expMsip});
    readCheck("mtimecmp low", mtimeCmpLoAddr, expCmp[31:0]);
    readCheck("mtimecmp high", mtimeCmpHiAddr, expCmp[63:32]);
    expectValue("mTimerInt", 64'd0, 64'(mTimerInt));
    expectValue("mSwInt", 64'd0, 64'(mSwInt));
    endTest();

    beginTest("software interrupt");
    wbWrite(msipAddr, 32'd1, 4'hF);
    expMsip = 1'b1;
    readCheck("msip after set", msipAddr, {31'd0, expMsip});
    expectValue("mSwInt after set", 64'd1, 64'(mSwInt));
    // Upper bits of the write are random and must never read back
    data = nextRandom() & ~32'd1;
    wbWrite(msipAddr, data, 4'hF);
    expMsip = 1'b0;
    readCheck("msip after clear", msipAddr, {31'd0, expMsip});
    expectValue("mSwInt after clear", 64'd0, 64'(mSwInt));
    endTest();

    beginTest("mtimecmp byte lanes");
    for (int i = 0; i < 32; i++) begin
      data = nextRandom();
      rnd = nextRandom();
      // Odd passes target the high half so both halves see 16 writes
      if (i % 2 == 1) begin
        expCmp[63:32] = mergeBytes(expCmp[63:32], data, rnd[3:0]);
        wbWrite(mtimeCmpHiAddr, data, rnd[3:0]);
        readCheck("mtimecmp high readback", mtimeCmpHiAddr, expCmp[63:32]);
      end else begin
        expCmp[31:0] = mergeBytes(expCmp[31:0], data, rnd[3:0]);
        wbWrite(mtimeCmpLoAddr, data, rnd[3:0]);
        readCheck("mtimecmp low readback", mtimeCmpLoAddr, expCmp[31:0]);
      end
    end
    endTest();

    beginTest("mtime write and count");
    wbWrite(mtimeHiAddr, timeHiStart, 4'hF);
    wbWrite(mtimeLoAddr, timeLoStart, 4'hF);
    // Reading the high half first gives the low half two ticks before it is sampled
    wbRead(mtimeHiAddr, hi);
    wbRead(mtimeLoAddr, lo1);
    expectValue("mtime high unchanged", 64'(timeHiStart), 64'(hi));
    expectValue("mtime low in window", 64'd1,
                64'(lo1 >= timeLoStart + 32'd2 && lo1 <= timeLoStart + 32'd12));
    wbRead(mtimeLoAddr, lo2);
    expectValue("mtime low increasing", 64'd1, 64'(lo2 > lo1));
    // The port has moved one tick past the value latched into the read data
    expectValue("mtime port", {timeHiStart, lo2 + 32'd1}, mtime);
    endTest();

    beginTest("timer interrupt");
    wbRead(mtimeHiAddr, hi);
    wbRead(mtimeLoAddr, lo1);
    target = {hi, lo1} + 64'd200;
    wbWrite(mtimeCmpHiAddr, target[63:32], 4'hF);
    wbWrite(mtimeCmpLoAddr, target[31:0], 4'hF);
    expCmp = target;
    // Registers take the write one edge after the acknowledge
    @(negedge HCLK);
    expectValue("mTimerInt low after arming", 64'd0, 64'(mTimerInt));
    waited = 0;
    while (!mTimerInt && waited < timerLimit) begin
      @(negedge HCLK);
      waited++;
    end
    expectValue("mTimerInt high in time", 64'd1, 64'(mTimerInt));
    wbWrite(mtimeCmpLoAddr, 32'd0, 4'hF);
    wbWrite(mtimeCmpHiAddr, 32'd0, 4'hF);
    expCmp = 64'd0;
    @(negedge HCLK);
    expectValue("mTimerInt with zero compare", 64'd1, 64'(mTimerInt));
    wbWrite(mtimeCmpLoAddr, 32'hFFFF_FFFF, 4'hF);
    wbWrite(mtimeCmpHiAddr, 32'hFFFF_FFFF, 4'hF);
    expCmp = 64'hFFFF_FFFF_FFFF_FFFF;
    @(negedge HCLK);
    expectValue("mTimerInt with all ones compare", 64'd0, 64'(mTimerInt));
    endTest();

    beginTest("unmapped addresses");
    foreach (unmappedAddrs[i]) begin
      readCheck("unmapped read", unmappedAddrs[i], 32'd0);
      wbWrite(unmappedAddrs[i], nextRandom(), 4'hF);
    end
    readCheck("msip after unmapped writes", msipAddr, {31'd0, expMsip});
    readCheck("mtimecmp low after unmapped writes", mtimeCmpLoAddr, expCmp[31:0]);
    readCheck("mtimecmp high after unmapped writes", mtimeCmpHiAddr, expCmp[63:32]);
    endTest();

    $display("%0d tests run, %0d passed, %0d failed", testsPassed + testsFailed,
             testsPassed, testsFailed);
    if (testsFailed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- mtimeCounter.sv
`default_nettype none

module mtimeCounter (
  input  logic                           HCLK,
  input  logic                           HRESETn,
  // Registered write port from the bus slave
  input  clintPkg::clintReg_e            regSel,
  input  logic                           writeEn,
  input  logic [clintPkg::byteLanes-1:0] byteEn,
  input  logic [clintPkg::dataWidth-1:0] writeData,
  // Free-running machine time
  output logic [clintPkg::timeWidth-1:0] mtime
);

  import clintPkg::*;

  logic                 writeLo;
  logic                 writeHi;
  logic [timeWidth-1:0] mtimeNext;

  // Write hits on either half of the counter
  assign writeLo = writeEn & (regSel == regTimeLo);
  assign writeHi = writeEn & (regSel == regTimeHi);

  //////////////////////////////////////////////////////////////////////
  // Next count value
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Normal case is one tick per HCLK edge
    mtimeNext = mtime + 64'd1;
    if (writeLo) begin
      // The written half takes the selected bytes
      // The other half keeps its value and the count pauses for this edge
      mtimeNext = {mtime[timeWidth-1:dataWidth],
                   byteMerge(mtime[dataWidth-1:0], writeData, byteEn)};
    end else if (writeHi) begin
      mtimeNext = {byteMerge(mtime[timeWidth-1:dataWidth], writeData, byteEn),
                   mtime[dataWidth-1:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counter register
  //////////////////////////////////////////////////////////////////////

  // Time restarts from zero after reset
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      mtime <= '0;
    end else begin
      mtime <= mtimeNext;
    end
  end

endmodule

`default_nettype wire
